/* rv_exec_core.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/exec_if.sv
rtl/rv_decoder.sv
rtl/reg_file.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/retire_unit.sv
rtl/rv_exec_core.sv
verif/rv_exec_core_assert.sv
verif/rv_exec_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run of rv_exec_core_tb
rm -f sim.log
verilator --binary --timing --assert -f rv_exec_core.f --top-module rv_exec_core_tb \
    -o rv_exec_core_sim > build.log 2>&1 &&
    ./obj_dir/rv_exec_core_sim > sim.log 2>&1
grep -q "Finished with no errors" sim.log && echo "simulation passed" && exit 0 ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* verif/rv_exec_core_tb.sv */
// testbench for the rv32i execution core
`timescale 1ns/1ps
`include "core_consts.svh"

module rv_exec_core_tb
    import rv_isa_pkg::*;
();

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic             we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } ret_rec_t;

    logic             clk;
    logic             reset;
    logic             inst_valid;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    logic             retire_valid;
    logic [`XLEN-1:0] retire_pc;
    logic             retire_we;
    logic [4:0]       retire_rd;
    logic [`XLEN-1:0] retire_data;

    logic [`XLEN-1:0] ref_regs [`REG_COUNT];
    logic [`XLEN-1:0] ref_pc;
    ret_rec_t         exp_q [$];
    int               stim_errors;
    int               cmp_errors;
    int               retired;
    int               tests;
    int               err_base;

    rv_exec_core dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk; // 20 ns period

    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // returns the expected retire record and advances the model state
    function automatic ret_rec_t ref_exec(input logic [31:0] w);
        ret_rec_t    r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] nxt;
        logic        take;
        a      = ref_regs[w[19:15]];
        b      = ref_regs[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        nxt    = ref_pc + 32'd4;
        take   = 1'b0;
        r.pc   = ref_pc;
        r.we   = 1'b1;
        r.rd   = w[11:7];
        r.data = 32'h0;
        case (w[6:0])
            OPC_OP:     r.data = alu_calc(w[14:12], w[30], a, b);
            OPC_OP_IMM: r.data = alu_calc(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
            OPC_LUI:    r.data = {w[31:12], 12'h0};
            OPC_AUIPC:  r.data = ref_pc + {w[31:12], 12'h0};
            OPC_JAL: begin
                r.data = nxt; // link
                nxt    = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                r.data = nxt;
                nxt    = (a + imm_i) & ~32'h1;
            end
            OPC_BRANCH: begin
                r.we = 1'b0;
                case (w[14:12])
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) nxt = ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            default: r.we = 1'b0; // load, store, system
        endcase
        if (r.we && r.rd != 5'd0) ref_regs[r.rd] = r.data;
        ref_pc = nxt;
        return r;
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic issue(input logic [31:0] w);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = w;
        exp_q.push_back(ref_exec(w));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_valid = 1'b0;
            inst       = $urandom; // ignored while invalid
        end
    endtask

    // drain outstanding retires, then check pc and report
    task automatic close_test(input string name);
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d instructions never retired in %s", exp_q.size(), name);
            stim_errors++;
        end
        if (pc !== ref_pc) begin
            $display("FAIL pc: got %h expected %h", pc, ref_pc);
            stim_errors++;
        end
        tests++;
        $display("test %0d %s: %0d errors", tests, name, stim_errors + cmp_errors - err_base);
        err_base = stim_errors + cmp_errors;
    endtask

    // compare each retire with the oldest expected record
    always @(negedge clk) begin
        ret_rec_t e;
        if (!reset && retire_valid) begin
            retired++;
            if (exp_q.size() == 0) begin
                $display("ERROR: retire at pc %h with no instruction outstanding", retire_pc);
                cmp_errors++;
            end else begin
                e = exp_q.pop_front();
                if (retire_pc !== e.pc) begin
                    $display("FAIL retire_pc: got %h expected %h", retire_pc, e.pc);
                    cmp_errors++;
                end
                if (retire_we !== e.we) begin
                    $display("FAIL retire_we: got %h expected %h", retire_we, e.we);
                    cmp_errors++;
                end
                if (e.we && retire_rd !== e.rd) begin
                    $display("FAIL retire_rd: got %h expected %h", retire_rd, e.rd);
                    cmp_errors++;
                end
                if (e.we && retire_data !== e.data) begin
                    $display("FAIL retire_data: got %h expected %h", retire_data, e.data);
                    cmp_errors++;
                end
            end
        end
    end

    initial begin
        #200_000;
        $display("ERROR: simulation watchdog expired");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [6:0]  f7;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        void'($urandom(32'h2883));
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        stim_errors = 0;
        cmp_errors  = 0;
        retired     = 0;
        tests       = 0;
        err_base    = 0;
        ref_pc      = `RESET_PC;
        for (int i = 0; i < `REG_COUNT; i++) ref_regs[i] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        if (pc !== `RESET_PC) begin
            $display("FAIL pc: got %h expected %h", pc, `RESET_PC);
            stim_errors++;
        end
        repeat (5) begin
            @(negedge clk);
            if (retire_valid !== 1'b0) begin
                $display("ERROR: retire_valid high with no instruction presented");
                stim_errors++;
            end
        end
        close_test("reset state");

        // fill x1..x31 then random alu ops back to back
        for (int i = 1; i < 32; i++) begin
            w = $urandom;
            issue({w[31:12], 5'(i), OPC_LUI});
            issue({w[11:0], 5'(i), 3'd0, 5'(i), OPC_OP_IMM});
        end
        for (int i = 0; i < 60; i++) begin
            w  = $urandom;
            f3 = w[2:0];
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && w[18]) ? 7'h20 : 7'h00;
            if (w[19]) begin
                issue({f7, w[12:8], w[7:3], f3, w[17:13], OPC_OP});
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                issue({f7, w[12:8], w[7:3], f3, w[17:13], OPC_OP_IMM});
            end else begin
                issue({w[31:20], w[7:3], f3, w[17:13], OPC_OP_IMM});
            end
        end
        close_test("alu ops");

        for (int i = 0; i < 16; i++) begin
            w = $urandom;
            issue({w[31:12], w[11:7], w[0] ? OPC_LUI : OPC_AUIPC});
            if (w[1]) idle(1);
        end
        close_test("upper immediates");

        for (int i = 0; i < 40; i++) begin
            w   = $urandom;
            rs1 = w[4:0];
            f3  = w[14:12];
            if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
            issue(enc_b({w[31:21], 2'b00}, (w[6:5] == 2'b00) ? rs1 : w[11:7], rs1, f3));
        end
        close_test("branches");

        for (int i = 0; i < 12; i++) begin
            w = $urandom;
            if (w[5]) begin
                issue(enc_j({w[31:13], 2'b00}, w[4:0]));
            end else begin
                issue({w[31:12], 5'd31, OPC_LUI}); // word aligned base
                issue({w[15:6], 2'b01, 5'd31, 3'd0, w[4:0], OPC_JALR});
            end
        end
        close_test("jumps");

        issue({12'h07b, 5'd0, 3'd0, 5'd0, OPC_OP_IMM});
        issue({7'h00, 5'd0, 5'd0, 3'd0, 5'd7, OPC_OP}); // x7 = x0 + x0
        w = $urandom;
        issue({w[31:7], OPC_LOAD});
        issue({w[31:7], OPC_STORE});
        issue({w[31:7], OPC_SYSTEM});
        close_test("x0 and unsupported opcodes");

        $display("tests %0d, retired %0d, errors %0d", tests, retired, stim_errors + cmp_errors);
        if (stim_errors + cmp_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verif/rv_exec_core_assert.sv */
// retire and pc checks for the core
`timescale 1ns/1ps
`include "core_consts.svh"

module rv_exec_core_assert (
    input logic             clk,
    input logic             reset,
    input logic             inst_valid,
    input logic [`XLEN-1:0] pc,
    input logic             retire_valid,
    input logic             retire_we
);

    // quiet through reset and the cycle after
    a_reset_quiet: assert property (@(posedge clk) reset |=> !retire_valid)
        else $error("retire_valid high after a reset cycle");

    a_one_per_strobe: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> retire_valid == $past(inst_valid))
        else $error("retire_valid does not follow inst_valid by one cycle");

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    a_we_needs_valid: assert property (@(posedge clk) disable iff (reset)
        retire_we |-> retire_valid)
        else $error("retire_we high without retire_valid");

endmodule

bind rv_exec_core rv_exec_core_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_we    (retire_we)
);

/* rtl/rv_exec_core.sv */
// rv32i integer execution core
`timescale 1ns/1ps
`include "core_consts.svh"

module rv_exec_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  logic [`XLEN-1:0]        inst,
    output logic [`XLEN-1:0]        pc,
    output logic                    retire_valid,
    output logic [`XLEN-1:0]        retire_pc,
    output logic                    retire_we,
    output logic [`REG_ADDR_W-1:0]  retire_rd,
    output logic [`XLEN-1:0]        retire_data
);

    logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [`XLEN-1:0]       rs1_data, rs2_data;
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`XLEN-1:0]       wr_data;
    logic [`XLEN-1:0]       alu_result;
    logic                   taken;
    logic [`XLEN-1:0]       target;

    exec_if dec_bus ();

    rv_decoder u_decoder (
        .inst       (inst),
        .inst_valid (inst_valid),
        .pc         (pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec        (dec_bus.decode)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // alu and branch resolve side by side
    int_alu u_alu (
        .dec        (dec_bus.alu),
        .alu_result (alu_result)
    );

    branch_unit u_branch (
        .dec    (dec_bus.branch),
        .taken  (taken),
        .target (target)
    );

    retire_unit u_retire (
        .clk          (clk),
        .reset        (reset),
        .dec          (dec_bus.retire),
        .alu_result   (alu_result),
        .taken        (taken),
        .target       (target),
        .pc           (pc),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

/* rtl/retire_unit.sv */
// pc, write-back and retire record
`timescale 1ns/1ps
`include "core_consts.svh"

module retire_unit
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    exec_if.retire                  dec,
    input  logic [`XLEN-1:0]        alu_result,
    input  logic                    taken,
    input  logic [`XLEN-1:0]        target,
    output logic [`XLEN-1:0]        pc,
    output logic                    wr_en,
    output logic [`REG_ADDR_W-1:0]  wr_addr,
    output logic [`XLEN-1:0]        wr_data,
    output logic                    retire_valid,
    output logic [`XLEN-1:0]        retire_pc,
    output logic                    retire_we,
    output logic [`REG_ADDR_W-1:0]  retire_rd,
    output logic [`XLEN-1:0]        retire_data
);

    logic [`XLEN-1:0] seq_pc;
    logic             writes;

    assign seq_pc = pc + `XLEN'(`INST_STEP);

    // branch and unsupported kinds leave the register file alone
    assign writes  = (dec.kind == KIND_ALU_REG) || (dec.kind == KIND_ALU_IMM) ||
                     (dec.kind == KIND_UPPER) || (dec.kind == KIND_JUMP);
    assign wr_en   = dec.valid && writes;
    assign wr_addr = dec.rd;
    assign wr_data = (dec.kind == KIND_JUMP) ? seq_pc : alu_result; // link value

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= `RESET_PC;
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= dec.valid;
            retire_we    <= wr_en;
            if (dec.valid) begin
                pc <= taken ? target : seq_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            retire_pc   <= dec.pc;
            retire_rd   <= wr_addr;
            retire_data <= wr_data;
        end
    end

endmodule

/* rtl/branch_unit.sv */
// branch and jump resolution
`timescale 1ns/1ps
`include "core_consts.svh"

module branch_unit
    import core_pkg::*;
(
    exec_if.branch           dec,
    output logic             taken,
    output logic [`XLEN-1:0] target
);

    logic [`XLEN-1:0] pc_rel;
    logic [`XLEN-1:0] reg_rel;

    assign pc_rel  = dec.pc + dec.imm;
    assign reg_rel = dec.rs1_data + dec.imm;

    always_comb begin
        taken  = 1'b0;
        target = pc_rel;
        case (dec.kind)
            KIND_BRANCH: begin
                case (dec.br_cond)
                    BR_EQ:   taken = (dec.rs1_data == dec.rs2_data);
                    BR_NE:   taken = (dec.rs1_data != dec.rs2_data);
                    BR_LT:   taken = ($signed(dec.rs1_data) < $signed(dec.rs2_data));
                    BR_GE:   taken = ($signed(dec.rs1_data) >= $signed(dec.rs2_data));
                    BR_LTU:  taken = (dec.rs1_data < dec.rs2_data);
                    BR_GEU:  taken = (dec.rs1_data >= dec.rs2_data);
                    default: taken = 1'b0; // reserved funct3 falls through
                endcase
            end
            KIND_JUMP: begin
                taken = 1'b1;
                if (dec.br_cond == BR_JALR) begin
                    target = {reg_rel[`XLEN-1:1], 1'b0}; // jalr drops bit 0
                end
            end
            default: taken = 1'b0;
        endcase
    end

endmodule

/* rtl/int_alu.sv */
// integer alu
`timescale 1ns/1ps
`include "core_consts.svh"

module int_alu
    import core_pkg::*;
(
    exec_if.alu              dec,
    output logic [`XLEN-1:0] alu_result
);

    logic [4:0] shamt;

    assign shamt = dec.op_b[4:0]; // low 5 bits only

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = dec.op_a + dec.op_b;
            ALU_SUB:  alu_result = dec.op_a - dec.op_b;
            ALU_SLL:  alu_result = dec.op_a << shamt;
            ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}},
                                    $signed(dec.op_a) < $signed(dec.op_b)};
            ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, dec.op_a < dec.op_b};
            ALU_XOR:  alu_result = dec.op_a ^ dec.op_b;
            ALU_SRL:  alu_result = dec.op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(dec.op_a) >>> shamt);
            ALU_OR:   alu_result = dec.op_a | dec.op_b;
            ALU_AND:  alu_result = dec.op_a & dec.op_b;
            default:  alu_result = '0;
        endcase
    end

endmodule

/* rtl/reg_file.sv */
// integer register file
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`REG_ADDR_W-1:0]  rs1_addr,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data,
    input  logic                    wr_en,
    input  logic [`REG_ADDR_W-1:0]  wr_addr,
    input  logic [`XLEN-1:0]        wr_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin // x0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational read
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* rtl/rv_decoder.sv */
// instruction decoder
`timescale 1ns/1ps
`include "core_consts.svh"

module rv_decoder
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  rv_inst_u                inst,
    input  logic                    inst_valid,
    input  logic [`XLEN-1:0]        pc,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    exec_if.decode                  dec
);

    inst_kind_e       kind;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] imm_i, imm_b, imm_u, imm_j;

    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_b = {{20{inst.r.funct7[6]}}, inst.r.rd[0], inst.r.funct7[5:0],
                    inst.r.rd[4:1], 1'b0};
    assign imm_u = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
    assign imm_j = {{12{inst.r.funct7[6]}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                    inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;

    // opcode class, immediate and branch condition
    always_comb begin
        kind        = KIND_NONE;
        imm         = '0;
        dec.br_cond = br_cond_e'(inst.r.funct3);
        case (inst.r.opcode)
            OPC_OP:     kind = KIND_ALU_REG;
            OPC_OP_IMM: begin
                kind = KIND_ALU_IMM;
                imm  = imm_i;
            end
            OPC_LUI, OPC_AUIPC: begin
                kind = KIND_UPPER;
                imm  = imm_u;
            end
            OPC_JAL: begin
                kind        = KIND_JUMP;
                imm         = imm_j;
                dec.br_cond = BR_EQ; // funct3 bits are imm here
            end
            OPC_JALR: begin
                kind        = KIND_JUMP;
                imm         = imm_i;
                dec.br_cond = BR_JALR;
            end
            OPC_BRANCH: begin
                kind = KIND_BRANCH;
                imm  = imm_b;
            end
            OPC_LOAD, OPC_STORE, OPC_SYSTEM: kind = KIND_NONE;
            default:                         kind = KIND_NONE;
        endcase
    end

    always_comb begin
        dec.alu_op = ALU_ADD; // upper immediates add too
        if (kind == KIND_ALU_REG || kind == KIND_ALU_IMM) begin
            case (inst.r.funct3)
                3'b000: dec.alu_op = (kind == KIND_ALU_REG && inst.r.funct7[5]) ? ALU_SUB
                                                                              : ALU_ADD;
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL; // srai shares bit 30
                3'b110: dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

    // operand select
    always_comb begin
        dec.op_a = rs1_data;
        dec.op_b = rs2_data;
        case (kind)
            KIND_ALU_IMM: dec.op_b = imm;
            KIND_UPPER: begin
                dec.op_a = (inst.r.opcode == OPC_LUI) ? '0 : pc;
                dec.op_b = imm;
            end
            default: ;
        endcase
    end

    assign dec.kind     = kind;
    assign dec.imm      = imm;
    assign dec.rs1_data = rs1_data;
    assign dec.rs2_data = rs2_data;
    assign dec.rd       = inst.r.rd;
    assign dec.pc       = pc;
    assign dec.valid    = inst_valid;

endmodule

/* rtl/exec_if.sv */
// decoded instruction bundle
`timescale 1ns/1ps
`include "core_consts.svh"

interface exec_if
    import core_pkg::*;
();

    inst_kind_e              kind;
    alu_op_e                 alu_op;
    br_cond_e                br_cond;
    logic [`XLEN-1:0]        op_a;
    logic [`XLEN-1:0]        op_b;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    logic [`XLEN-1:0]        imm;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`XLEN-1:0]        pc;
    logic                    valid; // plain strobe without handshake

    modport decode (output kind, alu_op, br_cond, op_a, op_b, rs1_data, rs2_data,
                    imm, rd, pc, valid);
    modport alu    (input alu_op, op_a, op_b);
    modport branch (input kind, br_cond, rs1_data, rs2_data, imm, pc);
    modport retire (input kind, rd, pc, valid);

endinterface

/* rtl/core_pkg.sv */
// execution side types

package core_pkg;

    // decides write-back source and pc selection
    typedef enum logic [2:0] {
        KIND_ALU_REG,
        KIND_ALU_IMM,
        KIND_UPPER,
        KIND_JUMP,
        KIND_BRANCH,
        KIND_NONE
    } inst_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // branch conditions follow funct3 and the free 3'b010 marks jalr
    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_NE   = 3'b001,
        BR_JALR = 3'b010,
        BR_LT   = 3'b100,
        BR_GE   = 3'b101,
        BR_LTU  = 3'b110,
        BR_GEU  = 3'b111
    } br_cond_e;

endpackage

/* rtl/rv_isa_pkg.sv */
// rv32i instruction encodings

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011, // retired as no-op
        OPC_STORE  = 7'b0100011, // retired as no-op
        OPC_SYSTEM = 7'b1110011  // retired as no-op
    } opcode_e;

    // register-register layout and the source of b/u/j fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } rv_inst_u;

endpackage

/* rtl/core_consts.svh */
// core widths and reset values

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// pc after reset
`define RESET_PC 32'h8000_0000

// sequential pc increment
`define INST_STEP 4

`endif
